//--- Bender.yml
package:
  name: frame_fpga

sources:
  - include_dirs:
      - source
    files:
      - source/spi_pkg.sv
      - source/display_pkg.sv
      - source/spi_peripheral.sv
      - source/control_registers.sv
      - source/display_timing.sv
      - source/frame_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/frame_checker.sv
      - tests/frame_tb.sv

//--- frame_fpga.f
+incdir+source
source/spi_pkg.sv
source/display_pkg.sv
source/spi_peripheral.sv
source/control_registers.sv
source/display_timing.sv
source/frame_top.sv
tests/frame_checker.sv
tests/frame_tb.sv

//--- source/control_registers.sv
//####################################################################
// Register block behind the SPI peripheral
// Answers chip ID, enable and frame count reads one clock after
// the opcode. Writes land one clock after the operand pulse
// Frame counter wraps at 256 and only runs while enabled
//####################################################################

`timescale 1ns/10ps

`include "frame_defines.svh"

module control_registers (
    input  logic                            clock,
    input  logic                            reset,
    input  spi_pkg::spi_command_t           command,
    output spi_pkg::spi_response_t          response,
    input  logic                            frame_start,
    output display_pkg::display_config_t    display_config
);

    logic [7:0] frame_count;

    // Read responses
    always_ff @(posedge clock) begin
        if (reset) begin
            response <= '0;
        end else begin
            response.valid <= 1'b0;
            if (command.opcode_valid) begin
                case (command.opcode)
                    `OP_CHIP_ID: begin
                        response.data  <= `CHIP_ID;
                        response.valid <= 1'b1;
                    end
                    `OP_READ_ENABLE: begin
                        response.data  <= {7'd0, display_config.enable};
                        response.valid <= 1'b1;
                    end
                    `OP_FRAME_COUNT: begin
                        response.data  <= frame_count;
                        response.valid <= 1'b1;
                    end
                    default: ;  // Not ours, peripheral sends zero
                endcase
            end
        end
    end

    // Writes, keyed on the opcode held from the start of the transaction
    always_ff @(posedge clock) begin
        if (reset) begin
            display_config <= '0;
        end else if (command.operand_valid) begin
            case (command.opcode)
                `OP_DISPLAY_ENABLE: begin
                    if (command.operand_count == 8'd0) begin
                        display_config.enable <= command.operand[0];
                    end
                end
                `OP_BACKGROUND: begin
                    case (command.operand_count)
                        8'd0: display_config.colour.y  <= command.operand[3:0];
                        8'd1: display_config.colour.cb <= command.operand[2:0];
                        8'd2: display_config.colour.cr <= command.operand[2:0];
                        default: ;  // Extra operands ignored
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            frame_count <= 8'd0;
        end else if (frame_start && display_config.enable) begin
            frame_count <= frame_count + 8'd1;
        end
    end

endmodule

//--- source/display_pkg.sv
//####################################################################
// Display configuration and pixel pin types
// Colour is YCbCr with 4 bits of luma and 3 bits per chroma channel
// Sync pins are active low
//####################################################################

package display_pkg;

    typedef struct packed {
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } colour_t;

    // Written over SPI, sampled once per frame by the timing generator
    typedef struct packed {
        logic    enable;
        colour_t colour;
    } display_config_t;

    // Registered pin values
    typedef struct packed {
        logic    hsync;
        logic    vsync;
        colour_t pixel;
    } display_pins_t;

endpackage

//--- source/display_timing.sv
//####################################################################
// Raster timing with flat colour fill
// Line order is active, front porch, sync, back porch
// Configuration is sampled at the start of vsync, so a write lands
// on the next frame. All outputs are registered and aligned
//####################################################################

`timescale 1ns/10ps

`include "frame_defines.svh"

module display_timing (
    input  logic                         clock,
    input  logic                         reset,
    input  display_pkg::display_config_t display_config,
    output display_pkg::display_pins_t   pins,
    output logic                         frame_start
);

    localparam int H_TOTAL      = `H_TOTAL;
    localparam int V_TOTAL      = `V_TOTAL;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int H_WIDTH      = $clog2(H_TOTAL);
    localparam int V_WIDTH      = $clog2(V_TOTAL);

    logic [H_WIDTH-1:0] h_count;
    logic [V_WIDTH-1:0] v_count;
    logic line_end;
    logic h_sync_region;
    logic v_sync_region;
    logic active_region;
    logic frame_start_next;
    display_pkg::display_config_t shadow;

    assign line_end      = (h_count == H_WIDTH'(H_TOTAL - 1));
    assign h_sync_region = (h_count >= H_WIDTH'(H_SYNC_START)) &&
                           (h_count < H_WIDTH'(H_SYNC_START + `H_SYNC));
    assign v_sync_region = (v_count >= V_WIDTH'(V_SYNC_START)) &&
                           (v_count < V_WIDTH'(V_SYNC_START + `V_SYNC));
    assign active_region = (h_count < H_WIDTH'(`H_ACTIVE)) &&
                           (v_count < V_WIDTH'(`V_ACTIVE));
    assign frame_start_next = (h_count == '0) && (v_count == V_WIDTH'(V_SYNC_START));

    // Free running raster counters
    always_ff @(posedge clock) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= (v_count == V_WIDTH'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Once per frame, so a mid-frame write never tears the picture
    always_ff @(posedge clock) begin
        if (reset) begin
            shadow <= '0;
        end else if (frame_start_next) begin
            shadow <= display_config;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pins.hsync  <= 1'b1;
            pins.vsync  <= 1'b1;
            pins.pixel  <= '0;
            frame_start <= 1'b0;
        end else begin
            pins.hsync  <= ~h_sync_region;
            pins.vsync  <= ~v_sync_region;
            pins.pixel  <= (active_region && shadow.enable) ? shadow.colour : '0;
            frame_start <= frame_start_next;  // Same cycle vsync falls
        end
    end

endmodule

//--- source/frame_defines.svh
//####################################################################
// Opcodes, chip ID and raster sizes shared by the design
// Raster is shrunk for simulation and is far below a real panel
// Line and frame totals are derived, change only the parts
//####################################################################

`ifndef FRAME_DEFINES_SVH
`define FRAME_DEFINES_SVH

// SPI opcodes
`define OP_CHIP_ID        8'hDB
`define OP_DISPLAY_ENABLE 8'h20  // Operand 0 bit 0
`define OP_BACKGROUND     8'h21  // Operands 0..2 are Y, Cb, Cr
`define OP_READ_ENABLE    8'h22
`define OP_FRAME_COUNT    8'h24  // Low 8 bits of the frame count

`define CHIP_ID           8'h81

// Horizontal raster in system clocks
`define H_ACTIVE 16
`define H_FRONT  2
`define H_SYNC   4
`define H_BACK   2
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical raster in lines
`define V_ACTIVE 8
`define V_FRONT  1
`define V_SYNC   2
`define V_BACK   1
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`endif

//--- source/frame_top.sv
//####################################################################
// Display subsystem top, single clock and synchronous reset
// All pins are driven straight from registers in the sub-blocks
//####################################################################

`timescale 1ns/10ps

module frame_top (
    input  logic       clock,
    input  logic       reset,
    input  logic       spi_select,
    input  logic       spi_clock,
    input  logic       spi_data_in,
    output logic       spi_data_out,
    output logic       display_hsync,
    output logic       display_vsync,
    output logic [3:0] display_y,
    output logic [2:0] display_cb,
    output logic [2:0] display_cr
);

    spi_pkg::spi_command_t         command;
    spi_pkg::spi_response_t        response;
    display_pkg::display_config_t  display_config;
    display_pkg::display_pins_t    pins;
    logic                          frame_start;

    spi_peripheral spi_peripheral_i (
        .clock        (clock),
        .reset        (reset),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .command      (command),
        .response     (response)
    );

    control_registers control_registers_i (
        .clock          (clock),
        .reset          (reset),
        .command        (command),
        .response       (response),
        .frame_start    (frame_start),
        .display_config (display_config)
    );

    display_timing display_timing_i (
        .clock          (clock),
        .reset          (reset),
        .display_config (display_config),
        .pins           (pins),
        .frame_start    (frame_start)
    );

    // Pins out of the struct
    assign display_hsync = pins.hsync;
    assign display_vsync = pins.vsync;
    assign display_y     = pins.pixel.y;
    assign display_cb    = pins.pixel.cb;
    assign display_cr    = pins.pixel.cr;

endmodule

//--- source/spi_peripheral.sv
//####################################################################
// SPI mode 0 slave, MSB first, sampled on the system clock
// spi_clock must stay at least 8 system clocks per period
// Byte valid pulses come 3 clocks after the 8th rising edge is seen
// The response is sent in the second byte of a transaction only
// Raising spi_select drops any partial byte
//####################################################################

`timescale 1ns/10ps

module spi_peripheral (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   spi_select,
    input  logic                   spi_clock,
    input  logic                   spi_data_in,
    output logic                   spi_data_out,
    output spi_pkg::spi_command_t  command,
    input  spi_pkg::spi_response_t response
);

    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_last;  // Edge register
    logic       active;
    logic       rising;
    logic       falling;

    logic [2:0] bit_count;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] byte_count;  // Completed bytes in this transaction
    logic       byte_done;

    assign active  = ~select_sync[1];
    assign rising  = clock_sync[1] & ~clock_last;
    assign falling = ~clock_sync[1] & clock_last;

    // Two flop synchronizers on all inputs
    always_ff @(posedge clock) begin
        if (reset) begin
            select_sync <= 2'b11;
            clock_sync  <= 2'b00;
            data_sync   <= 2'b00;
            clock_last  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[0], spi_clock};
            data_sync   <= {data_sync[0], spi_data_in};
            clock_last  <= clock_sync[1];
        end
    end

    // Receive shifter
    always_ff @(posedge clock) begin
        if (rising) begin
            rx_shift <= {rx_shift[6:0], data_sync[1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !active) begin
            bit_count  <= 3'd0;
            byte_count <= 8'd0;
            byte_done  <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (rising) begin
                bit_count <= bit_count + 3'd1;
                byte_done <= (bit_count == 3'd7);
            end
            if (byte_done && byte_count != 8'hFF) begin
                byte_count <= byte_count + 8'd1;  // Saturates on long bursts
            end
        end
    end

    // First byte is the opcode, the rest are numbered operands
    always_ff @(posedge clock) begin
        if (reset) begin
            command <= '0;
        end else begin
            command.opcode_valid  <= byte_done && (byte_count == 8'd0);
            command.operand_valid <= byte_done && (byte_count != 8'd0);
            if (byte_done) begin
                if (byte_count == 8'd0) begin
                    command.opcode <= rx_shift;
                end else begin
                    command.operand       <= rx_shift;
                    command.operand_count <= byte_count - 8'd1;
                end
            end
        end
    end

    // Transmit shifter, zero unless a responder loaded it
    always_ff @(posedge clock) begin
        if (reset || !active) begin
            tx_shift     <= 8'd0;
            spi_data_out <= 1'b0;
        end else if (response.valid) begin
            tx_shift <= response.data;
        end else if (falling) begin
            spi_data_out <= tx_shift[7];  // Ready before the next rising edge
            tx_shift     <= {tx_shift[6:0], 1'b0};
        end
    end

endmodule

//--- source/spi_pkg.sv
//####################################################################
// Command and response types of the SPI opcode/operand protocol
// Valid flags are single system clock pulses
// operand_count restarts at 0 with every transaction
//####################################################################

package spi_pkg;

    // Decoded byte stream from the SPI peripheral
    typedef struct packed {
        logic [7:0] opcode;
        logic       opcode_valid;
        logic [7:0] operand;
        logic       operand_valid;
        logic [7:0] operand_count;
    } spi_command_t;

    // Byte returned to the host in the second byte of a transaction
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } spi_response_t;

endpackage

//--- tests/frame_checker.sv
//####################################################################
// Checker for the display pins of frame_top
// Locks onto the raster at the first hsync and vsync falling edges
// Expected pixels use the model state seen at each vsync fall, so
// model writes must settle between two vsync falls
//####################################################################

`timescale 1ns/10ps

`include "frame_defines.svh"

module frame_checker (
    input logic                 clock,
    input logic                 reset,
    input logic                 hsync,
    input logic                 vsync,
    input logic [3:0]           y,
    input logic [2:0]           cb,
    input logic [2:0]           cr,
    input logic                 model_enable,
    input display_pkg::colour_t model_colour
);

    localparam int LINE_CYCLES  = `H_TOTAL;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

    int    error_count   = 0;
    int    check_count   = 0;
    int    hsync_periods = 0;
    int    vsync_periods = 0;
    string test_name     = "startup";

    logic                 hsync_last;
    logic                 vsync_last;
    logic                 h_locked;
    logic                 v_locked;
    int                   h_pos = 0;  // Raster position of the pins
    int                   v_pos = 0;
    int                   h_since;
    int                   v_since;
    int                   h_low;
    int                   v_low;
    logic                 shadow_enable;
    display_pkg::colour_t shadow_colour;
    display_pkg::colour_t expected_pixel;
    logic [7:0]           frames_enabled;  // Frames the DUT should have counted

    task automatic begin_test(input string name);
        test_name = name;
        $display("running %s", name);
    endtask

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s %s expected 0x%0h actual 0x%0h",
                     test_name, label, expected, actual);
        end
    endtask

    task automatic report_error(input string message);
        error_count++;
        $display("error in %s %s", test_name, message);
    endtask

    task automatic check_frame_count(input logic [7:0] actual);
        check_value("frame count", {24'd0, frames_enabled}, {24'd0, actual});
    endtask

    task automatic finish_checks();
        if (hsync_periods == 0 || vsync_periods == 0) begin
            report_error("no complete hsync or vsync period was measured");
        end
        $display("checks %0d errors %0d", check_count, error_count);
    endtask

    // Pins change on the rising edge, sampled half a clock later
    always @(negedge clock) begin
        if (reset) begin
            hsync_last     = 1'b1;
            vsync_last     = 1'b1;
            h_locked       = 1'b0;
            v_locked       = 1'b0;
            h_since        = 0;
            v_since        = 0;
            h_low          = 0;
            v_low          = 0;
            shadow_enable  = 1'b0;
            shadow_colour  = '0;
            frames_enabled = 8'd0;
        end else begin
            h_pos   = (h_pos + 1) % LINE_CYCLES;
            h_since = h_since + 1;
            v_since = v_since + 1;
            if (hsync_last && !hsync) begin
                if (h_locked) begin
                    check_value("hsync period", LINE_CYCLES, h_since);
                    hsync_periods++;
                end
                h_locked = 1'b1;
                h_since  = 0;
                h_low    = 0;
                h_pos    = `H_ACTIVE + `H_FRONT;  // First sync cycle of a line
            end
            if (!hsync_last && hsync && h_locked) begin
                check_value("hsync low width", `H_SYNC, h_low);
            end
            if (!hsync) begin
                h_low++;
            end
            if (h_pos == 0) begin
                v_pos = (v_pos + 1) % `V_TOTAL;
            end

            // Frame start, the DUT takes its shadow copy here
            if (vsync_last && !vsync) begin
                if (v_locked) begin
                    check_value("vsync period", FRAME_CYCLES, v_since);
                    vsync_periods++;
                end
                v_locked      = 1'b1;
                v_since       = 0;
                v_low         = 0;
                v_pos         = `V_ACTIVE + `V_FRONT;
                shadow_enable = model_enable;
                shadow_colour = model_colour;
                if (model_enable) begin
                    frames_enabled = frames_enabled + 8'd1;
                end
            end
            if (!vsync_last && vsync && v_locked) begin
                check_value("vsync low width", `V_SYNC * LINE_CYCLES, v_low);
            end
            if (!vsync) begin
                v_low++;
            end

            expected_pixel = '0;  // Blanking or display off
            if (v_locked && shadow_enable && h_pos < `H_ACTIVE && v_pos < `V_ACTIVE) begin
                expected_pixel = shadow_colour;
            end
            check_value("pixel", expected_pixel, {y, cb, cr});
            hsync_last = hsync;
            vsync_last = vsync;
        end
    end

endmodule

//--- tests/frame_tb.sv
//####################################################################
// Testbench for frame_top with seeded random SPI traffic
// SPI mode 0 is bit-banged at 8 system clocks per bit
// Writes start right after a vsync fall so they land within a frame
// The model changes once a write transaction has ended
//####################################################################

`timescale 1ns/10ps

`include "frame_defines.svh"

module frame_tb;

    localparam int SEED       = 72755;
    localparam int WAIT_LIMIT = 3 * `H_TOTAL * `V_TOTAL;  // Three frames

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 spi_select;
    logic                 spi_clock;
    logic                 spi_data_in;
    logic                 spi_data_out;
    logic                 display_hsync;
    logic                 display_vsync;
    logic [3:0]           display_y;
    logic [2:0]           display_cb;
    logic [2:0]           display_cr;
    logic                 model_enable;
    display_pkg::colour_t model_colour;
    logic [7:0]           tx_bytes [0:3];

    frame_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .spi_select    (spi_select),
        .spi_clock     (spi_clock),
        .spi_data_in   (spi_data_in),
        .spi_data_out  (spi_data_out),
        .display_hsync (display_hsync),
        .display_vsync (display_vsync),
        .display_y     (display_y),
        .display_cb    (display_cb),
        .display_cr    (display_cr)
    );

    frame_checker frame_checker_i (
        .clock        (clock),
        .reset        (reset),
        .hsync        (display_hsync),
        .vsync        (display_vsync),
        .y            (display_y),
        .cb           (display_cb),
        .cr           (display_cr),
        .model_enable (model_enable),
        .model_colour (model_colour)
    );

    always #10 clock = ~clock;

    // Inputs always move 2 ns after a rising edge
    task automatic step(input int cycles);
        repeat (cycles) @(posedge clock);
        #2;
    endtask

    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_clock   = 1'b0;
            spi_data_in = tx[i];
            step(4);
            rx[i]     = spi_data_out;  // Sampled on the rising edge, as the host does
            spi_clock = 1'b1;
            step(4);
        end
    endtask

    task automatic spi_transfer(input int count, output logic [7:0] response);
        logic [7:0] rx;
        response   = 8'h00;
        spi_select = 1'b0;
        step(4);
        for (int b = 0; b < count; b++) begin
            spi_byte(tx_bytes[b], rx);
            if (b == 1) begin
                response = rx;
            end
        end
        spi_clock = 1'b0;
        step(4);
        spi_select = 1'b1;
        step(8);
    endtask

    task automatic read_register(input logic [7:0] opcode, output logic [7:0] value);
        tx_bytes[0] = opcode;
        tx_bytes[1] = 8'h00;
        spi_transfer(2, value);
    endtask

    task automatic wait_vsync_fall();
        logic last;
        logic seen;
        int   cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            last = display_vsync;
            step(1);
            cycles++;
            seen = last && !display_vsync;
        end
        if (!seen) begin
            frame_checker_i.report_error("timed out waiting for a vsync falling edge");
        end
    endtask

    task automatic write_enable(input logic [7:0] operand);
        logic [7:0] unused;
        wait_vsync_fall();
        tx_bytes[0] = `OP_DISPLAY_ENABLE;
        tx_bytes[1] = operand;
        spi_transfer(2, unused);
        model_enable = operand[0];
    endtask

    // Operands are Y, Cb, Cr from the top byte down
    task automatic write_colour(input logic [23:0] operands);
        logic [7:0] unused;
        wait_vsync_fall();
        tx_bytes[0] = `OP_BACKGROUND;
        tx_bytes[1] = operands[23:16];
        tx_bytes[2] = operands[15:8];
        tx_bytes[3] = operands[7:0];
        spi_transfer(4, unused);
        model_colour.y  = operands[19:16];
        model_colour.cb = operands[10:8];
        model_colour.cr = operands[2:0];
    endtask

    function automatic logic opcode_in_use(input logic [7:0] opcode);
        return opcode == `OP_CHIP_ID || opcode == `OP_DISPLAY_ENABLE ||
               opcode == `OP_BACKGROUND || opcode == `OP_READ_ENABLE ||
               opcode == `OP_FRAME_COUNT;
    endfunction

    initial begin
        #2_000_000;
        frame_checker_i.report_error("simulation ran past its time limit");
        frame_checker_i.finish_checks();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [7:0] value;
        logic [7:0] opcode;
        reset        = 1'b1;
        spi_select   = 1'b1;
        spi_clock    = 1'b0;
        spi_data_in  = 1'b0;
        model_enable = 1'b0;
        model_colour = '0;
        void'($urandom(SEED));
        step(5);
        reset = 1'b0;

        frame_checker_i.begin_test("reset state");
        frame_checker_i.check_value("hsync idle", 1, display_hsync);
        frame_checker_i.check_value("vsync idle", 1, display_vsync);
        wait_vsync_fall();
        wait_vsync_fall();  // One whole frame of black in between
        read_register(`OP_READ_ENABLE, value);
        frame_checker_i.check_value("read enable", 0, value);

        frame_checker_i.begin_test("chip id");
        read_register(`OP_CHIP_ID, value);
        frame_checker_i.check_value("chip id", `CHIP_ID, value);
        for (int n = 0; n < 4; n++) begin
            opcode = 8'($urandom);
            while (opcode_in_use(opcode)) begin
                opcode = 8'($urandom);
            end
            read_register(opcode, value);
            frame_checker_i.check_value("unknown opcode", 0, value);
        end

        frame_checker_i.begin_test("enable readback");
        for (int n = 0; n < 6; n++) begin
            write_enable(8'($urandom));
            read_register(`OP_READ_ENABLE, value);
            frame_checker_i.check_value("read enable", model_enable, value);
        end

        frame_checker_i.begin_test("background colour");
        write_enable(8'($urandom) | 8'h01);
        for (int n = 0; n < 4; n++) begin
            write_colour(24'($urandom));
            wait_vsync_fall();
            wait_vsync_fall();
        end

        frame_checker_i.begin_test("frame count");
        repeat (3) wait_vsync_fall();
        write_enable(8'($urandom) & 8'hFE);
        wait_vsync_fall();
        read_register(`OP_FRAME_COUNT, value);
        frame_checker_i.check_frame_count(value);

        frame_checker_i.finish_checks();
        if (frame_checker_i.error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
